// File: tb/warships_stimulus.txt
# C x y strobes | S cords hit (2 = no answer) | F x y cords hit2 | E my_ctr en_ctr state btn_en
# R ready2 level | V check both board views | X reset; x y in decimal pixels, cords in hex
E 0 0 0 0
V
C 20 20 0
C 500 70 0
C 156 240 0
E 1 0 0 0
C 156 240 0
C 188 288 0
C 124 320 0
E 3 0 0 0
C 284 208 0
E 4 0 0 1
C 220 384 0
E 4 0 0 1
V
R 1
C 500 70 1
R 0
E 4 4 4 0
S 99 0
F 546 208 00 1
S 23 1
E 3 3 2 0
C 546 208 0
F 562 224 11 0
S 23 0
F 578 240 22 1
S 00 0
F 594 256 33 1
S 55 1
F 610 272 44 1
E 2 0 6 0
V
C 626 288 0
S 71 2
E 2 0 6 0
X
E 0 0 0 0
V
C 140 224 0
C 172 256 0
C 204 304 0
C 268 368 0
E 4 0 0 1
R 1
C 500 70 1
R 0
E 4 4 4 0
S 12 1
F 546 208 00 0
S 34 1
F 562 224 11 0
S 66 1
F 578 240 22 0
S aa 1
E 0 4 7 0
V
C 594 256 0
S 00 2
E 0 4 7 0

// File: all.f
verilog/warships_pkg.sv
verilog/board_mem.sv
verilog/debounce.sv
verilog/player_ctrl.sv
verilog/main_fsm.sv
verilog/top_warships.sv
tb/tb_top_warships.sv

// File: tb/tb_top_warships.sv
`timescale 1ns/1ps

module tb_top_warships
    import warships_pkg::*;
();

    logic        control_clk;
    logic        rst_n;
    logic [11:0] cursor_x;
    logic [11:0] cursor_y;
    logic        left;
    logic        ready2;
    logic        hit2;
    logic [7:0]  ship_cords_in;
    logic        ready1;
    logic        hit1;
    logic [7:0]  ship_cords_out;
    logic [3:0]  my_ctr;
    logic [3:0]  en_ctr;
    logic [3:0]  state;
    logic        start_btn_en;
    logic [7:0]  view_my_addr;
    logic [1:0]  view_my_data;
    logic [7:0]  view_en_addr;
    logic [1:0]  view_en_data;

    // reference boards indexed by the coordinate word
    logic [1:0] my_model [0:255];
    logic [1:0] en_model [0:255];
    int         placed;

    integer     seed = 73;
    int         errors = 0;
    int         checks = 0;
    int         n_cmds = 0;
    int         cycle_cnt = 0;
    int         strobe_cnt = 0;
    int         strobe_cycle = 0;
    logic       strobe_hit;
    logic [7:0] strobe_cords;
    logic       ready1_q = 1'b0;

    int cmd_op[$];
    int cmd_a[$];
    int cmd_b[$];
    int cmd_c[$];
    int cmd_d[$];

    top_warships u_dut (.*);

    always #5 control_clk = ~control_clk;

    always @(posedge control_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ready1 strobes sampled mid cycle away from the rising edge
    always @(negedge control_clk) begin
        ready1_q <= ready1;
        if (ready1 === 1'b1 && ready1_q === 1'b0) begin
            strobe_cnt <= strobe_cnt + 1;
            strobe_cycle <= cycle_cnt;
            strobe_hit <= hit1;
            strobe_cords <= ship_cords_out;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("** Error %s: expected %0h, actual %0h at %0t", name, expected, actual,
                     $time);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s at %0t", what, $time);
            errors++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge control_clk);
    endtask

    function automatic bit in_rect(input int x, input int y, input int ox, input int oy,
                                   input int w, input int h);
        return (x >= ox) && (x < ox + w) && (y >= oy) && (y < oy + h);
    endfunction

    // row from the vertical offset, column from the horizontal one
    function automatic logic [7:0] cell_at(input int x, input int y, input int ox,
                                           input int oy);
        return ((y - oy) / cell_px) * 16 + (x - ox) / cell_px;
    endfunction

    task automatic click(input int x, input int y);
        cursor_x = x;
        cursor_y = y;
        left = 1'b1;
        idle(debounce_cycles + 4);
        left = 1'b0;
        // stays low until the debouncer has rearmed
        idle(debounce_cycles + 4);
    endtask

    task automatic wait_strobe(input int n0, input int limit, output bit got);
        int waited;
        waited = 0;
        while (strobe_cnt == n0 && waited < limit) begin
            @(negedge control_clk);
            waited++;
        end
        got = (strobe_cnt != n0);
    endtask

    task automatic read_views(input logic [7:0] cords, output logic [1:0] my_cell,
                              output logic [1:0] en_cell);
        view_my_addr = cords;
        view_en_addr = cords;
        idle(1);
        my_cell = view_my_data;
        en_cell = view_en_data;
    endtask

    task automatic check_boards();
        logic [1:0] my_cell;
        logic [1:0] en_cell;
        logic [7:0] cords;
        for (int r = 0; r < grid_size; r++) begin
            for (int c = 0; c < grid_size; c++) begin
                cords = r * 16 + c;
                read_views(cords, my_cell, en_cell);
                check_value($sformatf("own view %h", cords), my_model[cords], my_cell);
                check_value($sformatf("enemy view %h", cords), en_model[cords], en_cell);
            end
        end
    endtask

    task automatic reset_dut();
        rst_n = 1'b0;
        left = 1'b0;
        ready2 = 1'b0;
        hit2 = 1'b0;
        ship_cords_in = '0;
        idle(10);
        rst_n = 1'b1;
        for (int i = 0; i < 256; i++) begin
            my_model[i] = cell_empty;
            en_model[i] = cell_empty;
        end
        placed = 0;
        check_value("reset ready1", 0, ready1);
        check_value("reset hit1", 0, hit1);
        check_value("reset start_btn_en", 0, start_btn_en);
        check_value("reset ship_cords_out", 0, ship_cords_out);
        check_value("reset my_ctr", 0, my_ctr);
        check_value("reset en_ctr", 0, en_ctr);
        check_value("reset state", st_place, state);
        // clearing sweep writes every cell once
        idle(grid_size * grid_size + 4);
    endtask

    task automatic run_command(input int op, input int a, input int b, input int c,
                               input int d);
        int         n0;
        int         shot_cycle;
        bit         got;
        bit         exp_hit;
        logic [7:0] cords;
        logic [1:0] my_cell;
        logic [1:0] en_cell;
        n0 = strobe_cnt;
        case (op)
            "C": begin
                click(a, b);
                cords = cell_at(a, b, my_grid_x, my_grid_y);
                if (in_rect(a, b, my_grid_x, my_grid_y, grid_px, grid_px) &&
                        placed < ship_cells && my_model[cords] == cell_empty) begin
                    my_model[cords] = cell_ship;
                    placed++;
                end
                check_value("click strobes", c, strobe_cnt - n0);
            end
            "S": begin
                cords = a;
                ready2 = 1'b1;
                ship_cords_in = cords;
                shot_cycle = cycle_cnt;
                idle(1);
                ready2 = 1'b0;
                if (b == 2) begin
                    idle(8);
                    check_value("unanswered shot strobes", 0, strobe_cnt - n0);
                end else begin
                    wait_strobe(n0, 10, got);
                    check_true(got, "no ready1 answer arrived for the opponent shot");
                    exp_hit = (my_model[cords] == cell_ship);
                    check_true(b == exp_hit, "stimulus hit value disagrees with the board model");
                    check_value("answer latency", 3, strobe_cycle - shot_cycle);
                    check_value("answer hit1", exp_hit, strobe_hit);
                    if (exp_hit) begin
                        my_model[cords] = cell_hit;
                    end else if (my_model[cords] == cell_empty) begin
                        my_model[cords] = cell_miss;
                    end
                    read_views(cords, my_cell, en_cell);
                    check_value("own view after shot", my_model[cords], my_cell);
                end
            end
            "F": begin
                cords = c;
                click(a, b);
                wait_strobe(n0, 20, got);
                check_true(got, "no ready1 shot strobe after the enemy grid click");
                check_value("shot cords", cords, strobe_cords);
                // opponent answers with a one cycle strobe
                ready2 = 1'b1;
                hit2 = d[0];
                idle(1);
                ready2 = 1'b0;
                hit2 = 1'b0;
                idle(2);
                en_model[cords] = d[0] ? cell_hit : cell_miss;
                read_views(cords, my_cell, en_cell);
                check_value("enemy view after result", en_model[cords], en_cell);
            end
            "E": begin
                check_value("my_ctr", a, my_ctr);
                check_value("en_ctr", b, en_ctr);
                check_value("state", c, state);
                check_value("start_btn_en", d, start_btn_en);
            end
            "R": begin
                ready2 = a[0];
                // the new level is seen by at least one rising edge
                idle(1);
            end
            "V": check_boards();
            "X": reset_dut();
            default: check_true(1'b0, "unknown command in the stimulus file");
        endcase
    endtask

    initial begin
        int fd;
        int code;
        int ch;
        int op;
        int a;
        int b;
        int c;
        int d;
        control_clk = 1'b0;
        rst_n = 1'b0;
        cursor_x = '0;
        cursor_y = '0;
        left = 1'b0;
        ready2 = 1'b0;
        hit2 = 1'b0;
        ship_cords_in = '0;
        view_my_addr = '0;
        view_en_addr = '0;
        fd = $fopen("tb/warships_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tb/warships_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                a = 0;
                b = 0;
                c = 0;
                d = 0;
                code = $fscanf(fd, " %c", op);
                if (code == 1 && op == "#") begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else if (code == 1) begin
                    case (op)
                        "C": code = $fscanf(fd, "%d %d %d", a, b, c);
                        "S": code = $fscanf(fd, "%h %d", a, b);
                        "F": code = $fscanf(fd, "%d %d %h %d", a, b, c, d);
                        "E": code = $fscanf(fd, "%d %d %d %d", a, b, c, d);
                        "R": code = $fscanf(fd, "%d", a);
                        default: ;
                    endcase
                    cmd_op.push_back(op);
                    cmd_a.push_back(a);
                    cmd_b.push_back(b);
                    cmd_c.push_back(c);
                    cmd_d.push_back(d);
                end
            end
            $fclose(fd);
        end
        n_cmds = cmd_op.size();
        reset_dut();
        for (int i = 0; i < n_cmds; i++) begin
            run_command(cmd_op[i], cmd_a[i], cmd_b[i], cmd_c[i], cmd_d[i]);
            idle({$random(seed)} % 8);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // budget per command covers a reset with its sweep
    initial begin
        wait (n_cmds > 0);
        repeat (n_cmds * 200) @(posedge control_clk);
        $display("watchdog expired after %0d cycles with commands still running", n_cmds * 200);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: verilog/top_warships.sv
`timescale 1ns/1ps

module top_warships (
    input  logic        control_clk,
    input  logic        rst_n,
    input  logic [11:0] cursor_x,
    input  logic [11:0] cursor_y,
    input  logic        left,
    input  logic        ready2,
    input  logic        hit2,
    input  logic [7:0]  ship_cords_in,
    output logic        ready1,
    output logic        hit1,
    output logic [7:0]  ship_cords_out,
    output logic [3:0]  my_ctr,
    output logic [3:0]  en_ctr,
    output logic [3:0]  state,
    output logic        start_btn_en,
    input  logic [7:0]  view_my_addr,
    output logic [1:0]  view_my_data,
    input  logic [7:0]  view_en_addr,
    output logic [1:0]  view_en_data
);

    // mouse click path
    logic       left_db;
    logic [7:0] my_grid_cords;
    logic [7:0] en_grid_cords;
    logic       my_grid_sel;
    logic       en_grid_sel;
    logic       start_btn;

    // own board control port
    logic [7:0] my_board_addr;
    logic       my_board_w_nr;
    logic [1:0] my_board_wdata;
    logic [1:0] my_board_rdata;

    // enemy board control port
    logic [7:0] en_board_addr;
    logic       en_board_w_nr;
    logic [1:0] en_board_wdata;
    logic [1:0] en_board_rdata;

    debounce u_mouse_debounce (
        .control_clk,
        .rst_n,
        .left,
        .click(left_db)
    );

    player_ctrl u_player_ctrl (
        .control_clk,
        .rst_n,
        .click(left_db),
        .cursor_x,
        .cursor_y,
        .my_cords(my_grid_cords),
        .my_sel(my_grid_sel),
        .en_cords(en_grid_cords),
        .en_sel(en_grid_sel),
        .start_btn
    );

    main_fsm u_main_fsm (
        .control_clk,
        .rst_n,
        .my_cords(my_grid_cords),
        .my_sel(my_grid_sel),
        .en_cords(en_grid_cords),
        .en_sel(en_grid_sel),
        .start_btn,
        .my_mem_addr(my_board_addr),
        .my_mem_w_nr(my_board_w_nr),
        .my_mem_data_out(my_board_wdata),
        .my_mem_data_in(my_board_rdata),
        .en_mem_addr(en_board_addr),
        .en_mem_w_nr(en_board_w_nr),
        .en_mem_data_out(en_board_wdata),
        .en_mem_data_in(en_board_rdata),
        .ready1,
        .hit1,
        .ship_cords_out,
        .ready2,
        .hit2,
        .ship_cords_in,
        .my_ctr,
        .en_ctr,
        .start_btn_en,
        .state
    );

    board_mem u_my_board_mem (
        .control_clk,
        .rst_n,
        .addr(my_board_addr),
        .w_nr(my_board_w_nr),
        .write_data(my_board_wdata),
        .read_data(my_board_rdata),
        .view_addr(view_my_addr),
        .view_data(view_my_data)
    );

    board_mem u_enemy_board_mem (
        .control_clk,
        .rst_n,
        .addr(en_board_addr),
        .w_nr(en_board_w_nr),
        .write_data(en_board_wdata),
        .read_data(en_board_rdata),
        .view_addr(view_en_addr),
        .view_data(view_en_data)
    );

endmodule

// File: verilog/main_fsm.sv
`timescale 1ns/1ps

module main_fsm
    import warships_pkg::*;
(
    input  logic       control_clk,
    input  logic       rst_n,
    input  logic [7:0] my_cords,
    input  logic       my_sel,
    input  logic [7:0] en_cords,
    input  logic       en_sel,
    input  logic       start_btn,
    output logic [7:0] my_mem_addr,
    output logic       my_mem_w_nr,
    output logic [1:0] my_mem_data_out,
    input  logic [1:0] my_mem_data_in,
    output logic [7:0] en_mem_addr,
    output logic       en_mem_w_nr,
    output logic [1:0] en_mem_data_out,
    input  logic [1:0] en_mem_data_in,
    output logic       ready1,
    output logic       hit1,
    output logic [7:0] ship_cords_out,
    input  logic       ready2,
    input  logic       hit2,
    input  logic [7:0] ship_cords_in,
    output logic [3:0] my_ctr,
    output logic [3:0] en_ctr,
    output logic       start_btn_en,
    output logic [3:0] state
);

    logic [3:0] state_q;
    logic       step;
    logic       clearing;
    logic [3:0] clear_row;
    logic [3:0] clear_col;
    logic       answer_first;
    logic       ready2_q;
    logic       ready2_rise;
    logic       in_play;
    logic [7:0] my_target;
    logic [7:0] en_target;
    logic       res_hit;
    logic [1:0] answer_cell;

    assign state = state_q;
    assign in_play = (state_q != st_place) && (state_q != st_wait_ready);
    // in play the opponent strobes, so only a rising edge is an event
    assign ready2_rise = ready2 && !ready2_q;
    assign start_btn_en = (state_q == st_place) && !clearing && (my_ctr == 4'(ship_cells));

    // what an incoming shot leaves behind on the own board
    always_comb begin
        case (my_mem_data_in)
            cell_ship: answer_cell = cell_hit;
            cell_empty: answer_cell = cell_miss;
            default: answer_cell = my_mem_data_in;
        endcase
    end

    always_comb begin
        if (clearing) begin
            my_mem_addr = {clear_row, clear_col};
            my_mem_w_nr = 1'b1;
            my_mem_data_out = cell_empty;
        end else if (state_q == st_place) begin
            // first cycle reads the clicked cell, second writes if empty
            my_mem_addr = step ? my_target : my_cords;
            my_mem_w_nr = step && (my_mem_data_in == cell_empty);
            my_mem_data_out = cell_ship;
        end else begin
            my_mem_addr = my_target;
            my_mem_w_nr = (state_q == st_answer) && step;
            my_mem_data_out = answer_cell;
        end
    end

    always_comb begin
        if (clearing) begin
            en_mem_addr = {clear_row, clear_col};
            en_mem_w_nr = 1'b1;
            en_mem_data_out = cell_empty;
        end else begin
            en_mem_addr = (state_q == st_my_turn) ? en_cords : en_target;
            en_mem_w_nr = (state_q == st_await_result) && step;
            en_mem_data_out = res_hit ? cell_hit : cell_miss;
        end
    end

    always_ff @(posedge control_clk) begin
        if ((state_q == st_place) && !step && my_sel) begin
            my_target <= my_cords;
        end
        if ((state_q == st_their_turn) && ready2_rise) begin
            my_target <= ship_cords_in;
        end
        if ((state_q == st_my_turn) && !step && en_sel) begin
            en_target <= en_cords;
        end
        if ((state_q == st_await_result) && !step && ready2_rise) begin
            res_hit <= hit2;
        end
    end

    always_ff @(posedge control_clk) begin
        if (!rst_n) begin
            state_q <= st_place;
            step <= 1'b0;
            clearing <= 1'b1;
            clear_row <= '0;
            clear_col <= '0;
            answer_first <= 1'b0;
            ready2_q <= 1'b0;
            ready1 <= 1'b0;
            hit1 <= 1'b0;
            ship_cords_out <= '0;
            my_ctr <= '0;
            en_ctr <= '0;
        end else begin
            ready2_q <= ready2;
            // ready1 is a strobe once play has begun
            if (in_play) begin
                ready1 <= 1'b0;
            end
            case (state_q)
                st_place: begin
                    if (clearing) begin
                        if (clear_col == 4'(grid_size - 1)) begin
                            clear_col <= '0;
                            clear_row <= clear_row + 1'b1;
                            if (clear_row == 4'(grid_size - 1)) begin
                                clearing <= 1'b0;
                            end
                        end else begin
                            clear_col <= clear_col + 1'b1;
                        end
                    end else if (step) begin
                        step <= 1'b0;
                        if (my_mem_data_in == cell_empty) begin
                            my_ctr <= my_ctr + 1'b1;
                        end
                    end else if (my_sel && (my_ctr < 4'(ship_cells))) begin
                        step <= 1'b1;
                    end else if (start_btn && start_btn_en) begin
                        ready1 <= 1'b1;
                        answer_first <= ready2;
                        state_q <= st_wait_ready;
                    end
                end
                st_wait_ready: begin
                    if (ready2) begin
                        ready1 <= 1'b0;
                        en_ctr <= 4'(ship_cells);
                        state_q <= answer_first ? st_their_turn : st_my_turn;
                    end
                end
                st_my_turn: begin
                    if (step) begin
                        step <= 1'b0;
                        // already shot cells are ignored
                        if (en_mem_data_in == cell_empty) begin
                            ready1 <= 1'b1;
                            hit1 <= 1'b0;
                            ship_cords_out <= en_target;
                            state_q <= st_await_result;
                        end
                    end else if (en_sel) begin
                        step <= 1'b1;
                    end
                end
                st_await_result: begin
                    if (step) begin
                        step <= 1'b0;
                        if (res_hit) begin
                            en_ctr <= en_ctr - 1'b1;
                            state_q <= (en_ctr == 4'd1) ? st_won : st_their_turn;
                        end else begin
                            state_q <= st_their_turn;
                        end
                    end else if (ready2_rise) begin
                        step <= 1'b1;
                    end
                end
                st_their_turn: begin
                    if (ready2_rise) begin
                        state_q <= st_answer;
                    end
                end
                st_answer: begin
                    if (!step) begin
                        step <= 1'b1;
                    end else begin
                        step <= 1'b0;
                        ready1 <= 1'b1;
                        hit1 <= (my_mem_data_in == cell_ship);
                        if (my_mem_data_in == cell_ship) begin
                            my_ctr <= my_ctr - 1'b1;
                            state_q <= (my_ctr == 4'd1) ? st_lost : st_my_turn;
                        end else begin
                            state_q <= st_my_turn;
                        end
                    end
                end
                st_won, st_lost: begin
                    // final until reset
                end
                default: begin
                    state_q <= st_place;
                end
            endcase
        end
    end

    // each strobe is a single cycle wide
    a_ready1_strobe: assert property (@(posedge control_clk) disable iff (!rst_n)
        (in_play && ready1) |=> !ready1);

    // a counter at zero in play stays there
    a_my_ctr_floor: assert property (@(posedge control_clk) disable iff (!rst_n)
        (in_play && (my_ctr == 4'd0)) |=> (my_ctr == 4'd0));
    a_en_ctr_floor: assert property (@(posedge control_clk) disable iff (!rst_n)
        (in_play && (en_ctr == 4'd0)) |=> (en_ctr == 4'd0));

endmodule

// File: verilog/player_ctrl.sv
`timescale 1ns/1ps

module player_ctrl
    import warships_pkg::*;
(
    input  logic        control_clk,
    input  logic        rst_n,
    input  logic        click,
    input  logic [11:0] cursor_x,
    input  logic [11:0] cursor_y,
    output logic [7:0]  my_cords,
    output logic        my_sel,
    output logic [7:0]  en_cords,
    output logic        en_sel,
    output logic        start_btn
);

    logic [11:0] my_dx;
    logic [11:0] my_dy;
    logic [11:0] en_dx;
    logic [11:0] en_dy;
    logic [11:0] btn_dx;
    logic [11:0] btn_dy;
    logic        in_my_grid;
    logic        in_en_grid;
    logic        in_btn;

    // offsets wrap to large values left of or above an origin
    assign my_dx = cursor_x - 12'(my_grid_x);
    assign my_dy = cursor_y - 12'(my_grid_y);
    assign en_dx = cursor_x - 12'(en_grid_x);
    assign en_dy = cursor_y - 12'(en_grid_y);
    assign btn_dx = cursor_x - 12'(btn_x);
    assign btn_dy = cursor_y - 12'(btn_y);

    // so one unsigned compare per axis covers both edges
    assign in_my_grid = (my_dx < 12'(grid_px)) && (my_dy < 12'(grid_px));
    assign in_en_grid = (en_dx < 12'(grid_px)) && (en_dy < 12'(grid_px));
    assign in_btn = (btn_dx < 12'(btn_w)) && (btn_dy < 12'(btn_h));

    always_ff @(posedge control_clk) begin
        if (!rst_n) begin
            my_sel <= 1'b0;
            en_sel <= 1'b0;
            start_btn <= 1'b0;
        end else begin
            my_sel <= click && in_my_grid;
            en_sel <= click && in_en_grid;
            start_btn <= click && in_btn;
        end
    end

    // row in the upper nibble, column in the lower
    always_ff @(posedge control_clk) begin
        my_cords <= {4'(my_dy / cell_px), 4'(my_dx / cell_px)};
        en_cords <= {4'(en_dy / cell_px), 4'(en_dx / cell_px)};
    end

endmodule

// File: verilog/debounce.sv
`timescale 1ns/1ps

module debounce
    import warships_pkg::*;
(
    input  logic control_clk,
    input  logic rst_n,
    input  logic left,
    output logic click
);

    localparam int cnt_w = $clog2(debounce_cycles + 1);

    logic             left_q;
    logic [cnt_w-1:0] stable_cnt;
    logic             fired;

    always_ff @(posedge control_clk) begin
        if (!rst_n) begin
            left_q <= 1'b0;
            stable_cnt <= '0;
            fired <= 1'b0;
            click <= 1'b0;
        end else begin
            left_q <= left;
            click <= 1'b0;
            if (left != left_q) begin
                stable_cnt <= '0;
            end else if (stable_cnt != cnt_w'(debounce_cycles)) begin
                stable_cnt <= stable_cnt + 1'b1;
                // count completes on this edge
                if (stable_cnt == cnt_w'(debounce_cycles - 1)) begin
                    if (left_q && !fired) begin
                        click <= 1'b1;
                        fired <= 1'b1;
                    end else if (!left_q) begin
                        // stable release rearms the tick
                        fired <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// File: verilog/board_mem.sv
`timescale 1ns/1ps

module board_mem
    import warships_pkg::*;
(
    input  logic       control_clk,
    input  logic       rst_n,
    input  logic [7:0] addr,
    input  logic       w_nr,
    input  logic [1:0] write_data,
    output logic [1:0] read_data,
    input  logic [7:0] view_addr,
    output logic [1:0] view_data
);

    logic [1:0] cells [grid_size * grid_size];

    // row major with the row in the upper nibble
    function automatic int unsigned cell_index(input logic [7:0] cords);
        return cords[7:4] * grid_size + cords[3:0];
    endfunction

    function automatic logic on_board(input logic [7:0] cords);
        return (cords[7:4] < grid_size) && (cords[3:0] < grid_size);
    endfunction

    // control port reads return the old cell on a write
    always_ff @(posedge control_clk) begin
        if (w_nr) begin
            cells[cell_index(addr)] <= write_data;
        end
        read_data <= on_board(addr) ? cells[cell_index(addr)] : cell_empty;
    end

    // a display may scan the view port past the grid edge
    always_ff @(posedge control_clk) begin
        view_data <= on_board(view_addr) ? cells[cell_index(view_addr)] : cell_empty;
    end

    a_write_on_board: assert property (@(posedge control_clk) disable iff (!rst_n)
        w_nr |-> on_board(addr));

endmodule

// File: verilog/warships_pkg.sv
package warships_pkg;

    // board geometry
    localparam int grid_size = 12;
    localparam int cell_px = 16;
    localparam int grid_px = grid_size * cell_px;

    // pixel origins of both grids
    localparam int my_grid_x = 100;
    localparam int my_grid_y = 200;
    localparam int en_grid_x = 538;
    localparam int en_grid_y = 200;

    // start button rectangle
    localparam int btn_x = 448;
    localparam int btn_y = 40;
    localparam int btn_w = 128;
    localparam int btn_h = 64;

    localparam int ship_cells = 4;

    // cell codes stored in the board memories
    localparam logic [1:0] cell_empty = 2'd0;
    localparam logic [1:0] cell_ship = 2'd1;
    localparam logic [1:0] cell_miss = 2'd2;
    localparam logic [1:0] cell_hit = 2'd3;

    // game phases, visible on the state output
    localparam logic [3:0] st_place = 4'd0;
    localparam logic [3:0] st_wait_ready = 4'd1;
    localparam logic [3:0] st_my_turn = 4'd2;
    localparam logic [3:0] st_await_result = 4'd3;
    localparam logic [3:0] st_their_turn = 4'd4;
    localparam logic [3:0] st_answer = 4'd5;
    localparam logic [3:0] st_won = 4'd6;
    localparam logic [3:0] st_lost = 4'd7;

    // stable cycles before a button level counts
    localparam int debounce_cycles = 16;

endpackage
